// File: sbuf_pkg.sv
/*
 shared buffer package
 bank geometry, word types and the client request structs
*/
`default_nettype none

package sbuf_pkg;

  // ports per client, same count for write and read
  localparam int SBUF_NUM_PORTS  = 2;
  // 256 entries in total
  localparam int SBUF_ADDR_W     = 8;
  localparam int SBUF_NUM_BANKS  = 16;
  localparam int SBUF_BANK_SEL_W = $clog2(SBUF_NUM_BANKS);
  // low address bits index inside a bank
  localparam int SBUF_ENTRY_W    = SBUF_ADDR_W - SBUF_BANK_SEL_W;
  // one memory atomic, 8 elements of 8 bits
  localparam int SBUF_DATA_W     = 64;

  typedef logic [SBUF_ADDR_W-1:0]     sbuf_addr_t;
  typedef logic [SBUF_BANK_SEL_W-1:0] sbuf_bank_sel_t;
  typedef logic [SBUF_ENTRY_W-1:0]    sbuf_entry_t;
  typedef logic [SBUF_DATA_W-1:0]     sbuf_data_t;

  // one write port of one client
  typedef struct packed {
    logic       en;
    sbuf_addr_t addr;
    sbuf_data_t data;
  } sbuf_wr_req_t;

  // one read port of one client
  typedef struct packed {
    logic       en;
    sbuf_addr_t addr;
  } sbuf_rd_req_t;

  // upper bits name the bank
  function automatic sbuf_bank_sel_t sbuf_bank_of(sbuf_addr_t addr);
    return addr[SBUF_ADDR_W-1 -: SBUF_BANK_SEL_W];
  endfunction

  // lower bits name the entry inside the bank
  function automatic sbuf_entry_t sbuf_entry_of(sbuf_addr_t addr);
    return addr[SBUF_ENTRY_W-1:0];
  endfunction

  // one-hot bank hit, zero when the port is idle
  function automatic logic [SBUF_NUM_BANKS-1:0] sbuf_bank_dec(logic en, sbuf_addr_t addr);
    return en ? (SBUF_NUM_BANKS'(1) << sbuf_bank_of(addr)) : '0;
  endfunction

endpackage

`default_nettype wire

// File: sbuf_bank.sv
/*
 shared buffer bank
 16 words, one write port and one registered read port
*/
`default_nettype none

module sbuf_bank import sbuf_pkg::*; (
  input  logic        nvdla_core_clk,
  input  logic        we,
  input  sbuf_entry_t wa,
  input  sbuf_data_t  wd,
  input  logic        re,
  input  sbuf_entry_t ra,
  output sbuf_data_t  rd
);

  localparam int DEPTH = 1 << SBUF_ENTRY_W;

  // word storage
  sbuf_data_t mem [0:DEPTH-1];

  // write lands at the edge ending the request cycle
  always_ff @(posedge nvdla_core_clk) begin
    if (we) begin
      mem[wa] <= wd;
    end
  end

  // registered read
  // same-edge write is not visible yet, so the old word comes out
  // rd holds while re is low
  always_ff @(posedge nvdla_core_clk) begin
    if (re) begin
      rd <= mem[ra];
    end
  end

endmodule

`default_nettype wire

// File: sbuf_write_route.sv
/*
 shared buffer write routing
 steers every client write port onto the bank its address selects
*/
`default_nettype none

module sbuf_write_route import sbuf_pkg::*; #(
  parameter int num_clients = 2
) (
  input  sbuf_wr_req_t [num_clients-1:0][SBUF_NUM_PORTS-1:0] wr_req,
  output logic         [SBUF_NUM_BANKS-1:0]                  bank_we,
  output sbuf_entry_t  [SBUF_NUM_BANKS-1:0]                  bank_wa,
  output sbuf_data_t   [SBUF_NUM_BANKS-1:0]                  bank_wd
);

  //////////////////////////////
  // bank decode
  //////////////////////////////

  // one-hot bank hit per client and port
  logic [SBUF_NUM_BANKS-1:0] wr_sel [num_clients][SBUF_NUM_PORTS];

  for (genvar c = 0; c < num_clients; c++) begin : g_client
    for (genvar p = 0; p < SBUF_NUM_PORTS; p++) begin : g_port
      assign wr_sel[c][p] = sbuf_bank_dec(wr_req[c][p].en, wr_req[c][p].addr);
    end
  end

  //////////////////////////////
  // and-or merge per bank
  //////////////////////////////

  // only one client writes per cycle and its two ports never share a bank
  // so at most one term per bank is live, no priority needed
  always_comb begin
    bank_we = '0;
    bank_wa = '0;
    bank_wd = '0;
    for (int b = 0; b < SBUF_NUM_BANKS; b++) begin
      for (int c = 0; c < num_clients; c++) begin
        for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
          // strobe
          bank_we[b] |= wr_sel[c][p][b];
          // entry inside the bank
          bank_wa[b] |= {SBUF_ENTRY_W{wr_sel[c][p][b]}} &
                        sbuf_entry_of(wr_req[c][p].addr);
          // payload
          bank_wd[b] |= {SBUF_DATA_W{wr_sel[c][p][b]}} & wr_req[c][p].data;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sbuf_read_route.sv
/*
 shared buffer read routing, stage 1
 merges read ports into per-bank enables and entries, and registers
 which bank each port index read for the collect stage
*/
`default_nettype none

module sbuf_read_route import sbuf_pkg::*; #(
  parameter int num_clients = 2
) (
  input  logic                                                nvdla_core_clk,
  input  logic                                                rst,
  input  sbuf_rd_req_t [num_clients-1:0][SBUF_NUM_PORTS-1:0] rd_req,
  output logic         [SBUF_NUM_BANKS-1:0]                   bank_re,
  output sbuf_entry_t  [SBUF_NUM_BANKS-1:0]                   bank_ra,
  output logic [SBUF_NUM_PORTS-1:0][SBUF_NUM_BANKS-1:0]       port_bank_hit_d1,
  output logic         [SBUF_NUM_PORTS-1:0]                   port_rd_en_d1
);

  // one-hot bank hit per client and port
  logic [SBUF_NUM_BANKS-1:0] rd_sel [num_clients][SBUF_NUM_PORTS];

  // same hits folded over clients, per port index
  logic [SBUF_NUM_PORTS-1:0][SBUF_NUM_BANKS-1:0] port_bank_hit;
  logic [SBUF_NUM_PORTS-1:0]                     port_rd_en;

  for (genvar c = 0; c < num_clients; c++) begin : g_client
    for (genvar p = 0; p < SBUF_NUM_PORTS; p++) begin : g_port
      assign rd_sel[c][p] = sbuf_bank_dec(rd_req[c][p].en, rd_req[c][p].addr);
    end
  end

  //////////////////////////////
  // per port fold over clients
  //////////////////////////////

  // a single reader per cycle keeps each port vector one-hot or zero
  always_comb begin
    port_bank_hit = '0;
    port_rd_en    = '0;
    for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
      for (int c = 0; c < num_clients; c++) begin
        port_bank_hit[p] |= rd_sel[c][p];
        port_rd_en[p]    |= rd_req[c][p].en;
      end
    end
  end

  //////////////////////////////
  // per bank enable and entry
  //////////////////////////////

  always_comb begin
    bank_re = '0;
    bank_ra = '0;
    for (int b = 0; b < SBUF_NUM_BANKS; b++) begin
      for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
        bank_re[b] |= port_bank_hit[p][b];
        for (int c = 0; c < num_clients; c++) begin
          bank_ra[b] |= {SBUF_ENTRY_W{rd_sel[c][p][b]}} &
                        sbuf_entry_of(rd_req[c][p].addr);
        end
      end
    end
  end

  // stage 1 flags, line up with the bank read data one edge later
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      port_bank_hit_d1 <= '0;
      port_rd_en_d1    <= '0;
    end else begin
      port_bank_hit_d1 <= port_bank_hit;
      port_rd_en_d1    <= port_rd_en;
    end
  end

endmodule

`default_nettype wire

// File: sbuf_read_collect.sv
/*
 shared buffer read collect, stage 2
 picks each port's bank word and loads the port output register
*/
`default_nettype none

module sbuf_read_collect import sbuf_pkg::*; (
  input  logic                                          nvdla_core_clk,
  input  sbuf_data_t [SBUF_NUM_BANKS-1:0]               bank_rd,
  input  logic [SBUF_NUM_PORTS-1:0][SBUF_NUM_BANKS-1:0] port_bank_hit_d1,
  input  logic       [SBUF_NUM_PORTS-1:0]               port_rd_en_d1,
  output sbuf_data_t [SBUF_NUM_PORTS-1:0]               rd_data
);

  // selected word per port, before the output register
  sbuf_data_t [SBUF_NUM_PORTS-1:0] port_rdat;

  // and-or select
  // flags are one-hot or zero so no mux priority
  always_comb begin
    port_rdat = '0;
    for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
      for (int b = 0; b < SBUF_NUM_BANKS; b++) begin
        port_rdat[p] |= {SBUF_DATA_W{port_bank_hit_d1[p][b]}} & bank_rd[b];
      end
    end
  end

  // output register
  // loads only when a read reaches this stage, holds otherwise
  always_ff @(posedge nvdla_core_clk) begin
    for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
      if (port_rd_en_d1[p]) begin
        rd_data[p] <= port_rdat[p];
      end
    end
  end

endmodule

`default_nettype wire

// File: shared_buffer.sv
/*
 banked shared buffer
 256 words in 16 banks, shared by num_clients clients with two
 write and two read ports each, two-cycle read latency
*/
`default_nettype none

module shared_buffer import sbuf_pkg::*; #(
  parameter int num_clients = 2
) (
  input  logic                                                nvdla_core_clk,
  input  logic                                                rst,
  input  sbuf_wr_req_t [num_clients-1:0][SBUF_NUM_PORTS-1:0] wr_req,
  input  sbuf_rd_req_t [num_clients-1:0][SBUF_NUM_PORTS-1:0] rd_req,
  // same word for every client on a port index
  output sbuf_data_t   [SBUF_NUM_PORTS-1:0]                   rd_data
);

  // write side, per bank
  logic        [SBUF_NUM_BANKS-1:0] bank_we;
  sbuf_entry_t [SBUF_NUM_BANKS-1:0] bank_wa;
  sbuf_data_t  [SBUF_NUM_BANKS-1:0] bank_wd;

  // read side, per bank
  logic        [SBUF_NUM_BANKS-1:0] bank_re;
  sbuf_entry_t [SBUF_NUM_BANKS-1:0] bank_ra;
  sbuf_data_t  [SBUF_NUM_BANKS-1:0] bank_rd;

  // stage 1 flags
  logic [SBUF_NUM_PORTS-1:0][SBUF_NUM_BANKS-1:0] port_bank_hit_d1;
  logic [SBUF_NUM_PORTS-1:0]                     port_rd_en_d1;

  sbuf_write_route #(.num_clients(num_clients)) u_write_route (
    .wr_req  (wr_req),
    .bank_we (bank_we),
    .bank_wa (bank_wa),
    .bank_wd (bank_wd)
  );

  sbuf_read_route #(.num_clients(num_clients)) u_read_route (
    .nvdla_core_clk   (nvdla_core_clk),
    .rst              (rst),
    .rd_req           (rd_req),
    .bank_re          (bank_re),
    .bank_ra          (bank_ra),
    .port_bank_hit_d1 (port_bank_hit_d1),
    .port_rd_en_d1    (port_rd_en_d1)
  );

  // the 16 banks
  for (genvar b = 0; b < SBUF_NUM_BANKS; b++) begin : g_bank
    sbuf_bank u_bank (
      .nvdla_core_clk (nvdla_core_clk),
      .we             (bank_we[b]),
      .wa             (bank_wa[b]),
      .wd             (bank_wd[b]),
      .re             (bank_re[b]),
      .ra             (bank_ra[b]),
      .rd             (bank_rd[b])
    );
  end

  sbuf_read_collect u_read_collect (
    .nvdla_core_clk   (nvdla_core_clk),
    .bank_rd          (bank_rd),
    .port_bank_hit_d1 (port_bank_hit_d1),
    .port_rd_en_d1    (port_rd_en_d1),
    .rd_data          (rd_data)
  );

endmodule

`default_nettype wire

// File: tb_shared_buffer_ref.svh
/*
 shared buffer testbench reference
 stimulus LFSR, model memory and expected read words
*/
`ifndef TB_SHARED_BUFFER_REF_SVH
`define TB_SHARED_BUFFER_REF_SVH

// galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd71;

// model of all 256 buffer words
sbuf_data_t model_mem [0:255];

// one LFSR step per bit taken, low bit first
function automatic logic [63:0] rand_bits(int n);
  logic [63:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    bits[i] = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
  end
  return bits;
endfunction

// expected word for a read issued this cycle
// must run before model_write of the same cycle, a colliding write is not seen yet
function automatic sbuf_data_t ref_read_word(sbuf_addr_t addr);
  return model_mem[addr];
endfunction

function automatic void model_write(sbuf_addr_t addr, sbuf_data_t data);
  model_mem[addr] = data;
endfunction

`endif

// File: tb_shared_buffer.sv
/*
 shared buffer testbench
 random writes and reads through both clients, checked against a model
*/
`default_nettype none

module tb_shared_buffer import sbuf_pkg::*; ();

  localparam int NUM_CLIENTS = 2;
  // reset, fill, per-client, shared, burst, hold, read-during-write, drain
  localparam int TOTAL_CYCLES = 8 + 128 + 64 + 32 + 32 + 28 + 16 + 4;

  logic nvdla_core_clk = 1'b0;
  logic rst;
  sbuf_wr_req_t [NUM_CLIENTS-1:0][SBUF_NUM_PORTS-1:0] wr_req, wr_next;
  sbuf_rd_req_t [NUM_CLIENTS-1:0][SBUF_NUM_PORTS-1:0] rd_req, rd_next;
  sbuf_data_t   [SBUF_NUM_PORTS-1:0]                  rd_data;

  `include "tb_shared_buffer_ref.svh"

  // expected reads, in issue order
  sbuf_data_t exp_q [$];
  int         port_q [$];
  string      name_q [$];
  string      test_name = "reset";

  // compare side state
  logic [SBUF_NUM_PORTS-1:0] en_d1 = '0;
  logic [SBUF_NUM_PORTS-1:0] en_d2 = '0;
  logic [SBUF_NUM_PORTS-1:0] held_valid = '0;
  sbuf_data_t                held_word [SBUF_NUM_PORTS];
  int checks = 0;
  int value_errors = 0;
  int other_errors = 0;

  sbuf_addr_t addr0;
  sbuf_addr_t addr1;
  sbuf_data_t data0;
  sbuf_data_t data1;
  sbuf_addr_t saved_addr [16][2];

  shared_buffer #(.num_clients(NUM_CLIENTS)) uut (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .wr_req         (wr_req),
    .rd_req         (rd_req),
    .rd_data        (rd_data)
  );

  always #10 nvdla_core_clk = ~nvdla_core_clk;

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // fill word, every address bit shows up
  function automatic sbuf_data_t fill_word(sbuf_addr_t a);
    return {8{a}} ^ 64'h5A5A_0F0F_3C3C_9696;
  endfunction

  // random address in a different bank than a
  function automatic sbuf_addr_t other_bank_addr(sbuf_addr_t a);
    sbuf_bank_sel_t bank;
    sbuf_entry_t    entry;
    bank  = a[SBUF_ADDR_W-1 -: SBUF_BANK_SEL_W] ^ (sbuf_bank_sel_t'(rand_bits(3)) + 4'd1);
    entry = sbuf_entry_t'(rand_bits(SBUF_ENTRY_W));
    return {bank, entry};
  endfunction

  task automatic set_write(int c, int p, sbuf_addr_t a, sbuf_data_t d);
    wr_next[c][p] = '{en: 1'b1, addr: a, data: d};
  endtask

  task automatic set_read(int c, int p, sbuf_addr_t a);
    rd_next[c][p] = '{en: 1'b1, addr: a};
  endtask

  // queue expectations, update the model, then drive one cycle
  task automatic drive_cycle();
    for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (rd_next[c][p].en) begin
          exp_q.push_back(ref_read_word(rd_next[c][p].addr));
          port_q.push_back(p);
          name_q.push_back(test_name);
        end
      end
    end
    // writes after reads, read-before-write
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
        if (wr_next[c][p].en) begin
          model_write(wr_next[c][p].addr, wr_next[c][p].data);
        end
      end
    end
    @(posedge nvdla_core_clk);
    wr_req <= wr_next;
    rd_req <= rd_next;
    wr_next = '0;
    rd_next = '0;
  endtask

  //////////////////////////////
  // compare process
  //////////////////////////////

  // negedge sampling, requests and rd_data both settled
  always @(negedge nvdla_core_clk) begin : compare
    logic [SBUF_NUM_PORTS-1:0] cur_en;
    sbuf_data_t exp_word;
    int         exp_port;
    string      exp_name;
    cur_en = '0;
    for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        cur_en[p] |= rd_req[c][p].en;
      end
    end
    for (int p = 0; p < SBUF_NUM_PORTS; p++) begin
      if (en_d2[p]) begin
        assert (exp_q.size() > 0) else begin
          other_errors++;
          $display("port %0d returned a read but no expected word was queued", p);
        end
        if (exp_q.size() > 0) begin
          exp_word = exp_q.pop_front();
          exp_port = port_q.pop_front();
          exp_name = name_q.pop_front();
          assert (exp_port == p) else begin
            other_errors++;
            $display("queued read was for port %0d but port %0d completed", exp_port, p);
          end
          checks++;
          assert (rd_data[p] === exp_word) else begin
            value_errors++;
            $display("error %s port %0d: expected %h actual %h",
                     exp_name, p, exp_word, rd_data[p]);
          end
          held_word[p]  = exp_word;
          held_valid[p] = 1'b1;
        end
      end else if (held_valid[p]) begin
        // no read finished, output must hold
        checks++;
        assert (rd_data[p] === held_word[p]) else begin
          value_errors++;
          $display("error hold port %0d: expected %h actual %h", p, held_word[p], rd_data[p]);
        end
      end
    end
    en_d2 = en_d1;
    en_d1 = cur_en;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    rst     = 1'b1;
    wr_req  = '0;
    rd_req  = '0;
    wr_next = '0;
    rd_next = '0;
    repeat (8) @(posedge nvdla_core_clk);
    rst <= 1'b0;

    // banks power up unknown, write every word once
    test_name = "fill";
    for (int i = 0; i < 128; i++) begin
      set_write(0, 0, sbuf_addr_t'(i), fill_word(sbuf_addr_t'(i)));
      set_write(0, 1, sbuf_addr_t'(i + 128), fill_word(sbuf_addr_t'(i + 128)));
      drive_cycle();
    end

    // write then read back on the same client
    test_name = "same_client";
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      for (int n = 0; n < 16; n++) begin
        addr0 = sbuf_addr_t'(rand_bits(SBUF_ADDR_W));
        addr1 = other_bank_addr(addr0);
        data0 = rand_bits(SBUF_DATA_W);
        data1 = rand_bits(SBUF_DATA_W);
        set_write(c, 0, addr0, data0);
        set_write(c, 1, addr1, data1);
        drive_cycle();
        set_read(c, 0, addr0);
        set_read(c, 1, addr1);
        drive_cycle();
      end
    end

    // client 1 writes, client 0 reads
    test_name = "shared";
    for (int n = 0; n < 16; n++) begin
      saved_addr[n][0] = sbuf_addr_t'(rand_bits(SBUF_ADDR_W));
      saved_addr[n][1] = other_bank_addr(saved_addr[n][0]);
      set_write(1, 0, saved_addr[n][0], rand_bits(SBUF_DATA_W));
      set_write(1, 1, saved_addr[n][1], rand_bits(SBUF_DATA_W));
      drive_cycle();
    end
    for (int n = 0; n < 16; n++) begin
      set_read(0, 0, saved_addr[n][0]);
      set_read(0, 1, saved_addr[n][1]);
      drive_cycle();
    end

    // back to back reads, reader alternates
    test_name = "burst";
    for (int n = 0; n < 32; n++) begin
      addr0 = sbuf_addr_t'(rand_bits(SBUF_ADDR_W));
      set_read(n % 2, 0, addr0);
      set_read(n % 2, 1, other_bank_addr(addr0));
      drive_cycle();
    end

    // single read then idle, compare checks the hold
    test_name = "hold";
    for (int n = 0; n < 4; n++) begin
      set_read(n % 2, n % 2, sbuf_addr_t'(rand_bits(SBUF_ADDR_W)));
      drive_cycle();
      repeat (6) drive_cycle();
    end

    // same address read and written in one cycle
    test_name = "read_during_write";
    for (int n = 0; n < 8; n++) begin
      addr0 = sbuf_addr_t'(rand_bits(SBUF_ADDR_W));
      set_write(1, 0, addr0, rand_bits(SBUF_DATA_W));
      set_read(0, 0, addr0);
      drive_cycle();
      set_read(0, 0, addr0);
      drive_cycle();
    end

    // let the pipeline empty
    test_name = "drain";
    repeat (4) drive_cycle();

    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("%0d expected reads never came back", exp_q.size());
    end
    $display("summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TOTAL_CYCLES * 20 + 400);
    $display("watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
sbuf_pkg.sv
sbuf_bank.sv
sbuf_write_route.sv
sbuf_read_route.sv
sbuf_read_collect.sv
shared_buffer.sv
tb_shared_buffer.sv

// File: Bender.yml
package:
  name: shared_buffer

sources:
  # design
  - files:
      - sbuf_pkg.sv
      - sbuf_bank.sv
      - sbuf_write_route.sv
      - sbuf_read_route.sv
      - sbuf_read_collect.sv
      - shared_buffer.sv
  # testbench
  - target: test
    include_dirs:
      - .
    files:
      - tb_shared_buffer.sv
